// ==== src/tile_net_defs.svh ====
/*
 * Widths, mesh size, credit and buffer sizes, and EVA field positions
 * shared by the tile network interface. Include before any package or module.
 */
`ifndef TILE_NET_DEFS_SVH
`define TILE_NET_DEFS_SVH

`define DATA_W       32
`define ADDR_W       16
`define EVA_W        32
`define X_W          4
`define Y_W          4
`define REG_W        5
`define OP_EX_W      4
`define LOAD_INFO_W  4

`define NUM_TILES_X  4
`define DRAM_Y       8
`define BLOCK_WORDS  8

`define MAX_CREDITS  4
`define CREDIT_W     3
`define RET_DEPTH    2

// eva field positions
`define EPA_LSB      2
`define TG_X_LSB     26
`define TG_Y_LSB     22
`define GL_X_LSB     25
`define GL_Y_LSB     21

`endif

// ==== src/net_pkt_pkg.sv ====
/*
 * Network-side packet types: op and return codes, the request payload
 * word and the request and return packet layouts.
 */
`include "tile_net_defs.svh"

package net_pkt_pkg;

  typedef enum logic [1:0] {
    e_remote_load  = 2'd0,
    e_remote_store = 2'd1,
    e_remote_amo   = 2'd2
  } net_op_e;

  typedef enum logic [1:0] {
    e_return_int_wb   = 2'd0,
    e_return_float_wb = 2'd1,
    e_return_ifetch   = 2'd2,
    e_return_credit   = 2'd3
  } ret_type_e;

  // load info sits in the low bits of the payload word
  typedef struct packed {
    logic [`DATA_W-`LOAD_INFO_W-1:0] reserved;
    logic                            float_wb;
    logic                            is_unsigned;
    logic [1:0]                      size;
  } load_info_s;

  // store/amo data or load info, chosen by op
  typedef union packed {
    logic [`DATA_W-1:0] data;
    load_info_s         load_info;
  } payload_u;

  typedef struct packed {
    net_op_e               op;
    logic [`OP_EX_W-1:0]   op_ex;
    logic [`ADDR_W-1:0]    addr;
    payload_u              payload;
    logic [`REG_W-1:0]     reg_id;
    logic [`X_W-1:0]       src_x;
    logic [`Y_W-1:0]       src_y;
    logic [`X_W-1:0]       x;
    logic [`Y_W-1:0]       y;
  } req_pkt_s;

  typedef struct packed {
    ret_type_e             ret_type;
    logic [`DATA_W-1:0]    data;
    logic [`REG_W-1:0]     reg_id;
  } ret_pkt_s;

endpackage

// ==== src/core_req_pkg.sv ====
/*
 * Core-side types: the remote request the core presents and the
 * writeback response returned to its register files.
 */
`include "tile_net_defs.svh"

package core_req_pkg;

  typedef struct packed {
    logic [`EVA_W-1:0]       addr;
    logic [`DATA_W-1:0]      data;
    logic [`OP_EX_W-1:0]     mask;
    logic                    write_not_read;
    logic                    is_amo_op;
    logic [`OP_EX_W-1:0]     amo_type;
    logic [`REG_W-1:0]       reg_id;
    // {float_wb, is_unsigned, size[1:0]}
    logic [`LOAD_INFO_W-1:0] load_info;
  } remote_req_s;

  typedef struct packed {
    logic [`REG_W-1:0]       rd;
    logic [`DATA_W-1:0]      data;
  } wb_resp_s;

endpackage

// ==== src/eva_to_npa.sv ====
/*
 * Translates a core EVA into a node-physical address: destination x, y
 * and endpoint word address. Purely combinational.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module eva_to_npa (
  input  logic [`EVA_W-1:0]  eva_i,
  input  logic               dram_enable_i,
  input  logic [`X_W-1:0]    tgo_x_i,
  input  logic [`Y_W-1:0]    tgo_y_i,
  output logic [`X_W-1:0]    x_o,
  output logic [`Y_W-1:0]    y_o,
  output logic [`ADDR_W-1:0] epa_o,
  output logic               invalid_o
);

  localparam int OFS_W   = $clog2(`BLOCK_WORDS);
  localparam int COL_W   = $clog2(`NUM_TILES_X);
  // word address below the dram region bit
  localparam int DWORD_W = `EVA_W - 1 - `EPA_LSB;
  localparam int BLK_W   = DWORD_W - OFS_W;
  localparam logic [`Y_W-1:0] DRAM_ROW = `Y_W'(`DRAM_Y);

  logic [DWORD_W-1:0]       dram_word;
  logic [BLK_W-1:0]         block_idx;
  logic [OFS_W-1:0]         word_ofs;
  logic [DWORD_W-COL_W-1:0] dram_epa;

  assign dram_word = eva_i[`EVA_W-2:`EPA_LSB];
  assign block_idx = dram_word[DWORD_W-1:OFS_W];
  assign word_ofs  = dram_word[OFS_W-1:0];
  // blocks striped across columns, column bits squeezed out
  assign dram_epa  = {block_idx[BLK_W-1:COL_W], word_ofs};

  always_comb begin
    x_o       = '0;
    y_o       = '0;
    epa_o     = '0;
    invalid_o = 1'b0;

    if (eva_i[`EVA_W-1]) begin
      x_o[COL_W-1:0] = block_idx[COL_W-1:0];
      y_o            = DRAM_ROW;
      epa_o          = dram_epa[`ADDR_W-1:0];
      invalid_o      = ~dram_enable_i;
    end else if (eva_i[`EVA_W-1 -: 2] == 2'b01) begin
      // offsets relative to the tile group origin
      x_o   = tgo_x_i + eva_i[`TG_X_LSB +: `X_W];
      y_o   = tgo_y_i + eva_i[`TG_Y_LSB +: `Y_W];
      epa_o = eva_i[`EPA_LSB +: `ADDR_W];
    end else if (eva_i[`EVA_W-1 -: 3] == 3'b001) begin
      x_o   = eva_i[`GL_X_LSB +: `X_W];
      y_o   = eva_i[`GL_Y_LSB +: `Y_W];
      epa_o = eva_i[`EPA_LSB +: `ADDR_W];
    end else begin
      invalid_o = 1'b1;
    end
  end

endmodule

// ==== src/out_credit_counter.sv ====
/*
 * Up/down counter of outgoing request credits. Starts full after reset,
 * counts down per accepted packet and up per credit return strobe.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module out_credit_counter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sent_i,
  input  logic                 credit_return_i,
  output logic [`CREDIT_W-1:0] credits_o
);

  localparam logic [`CREDIT_W-1:0] FULL_CREDITS = `CREDIT_W'(`MAX_CREDITS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_o <= FULL_CREDITS;
    end else begin
      case ({sent_i, credit_return_i})
        2'b10:   credits_o <= credits_o - 1'b1;
        2'b01:   credits_o <= credits_o + 1'b1;
        // both or neither leave the count alone
        default: credits_o <= credits_o;
      endcase
    end
  end

  // more returns than requests sent
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_o <= FULL_CREDITS)
    else $error("credit count above maximum");

  // sender must have seen the empty count
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sent_i |-> credits_o != '0)
    else $error("packet sent with no credits left");

endmodule

// ==== src/return_fifo.sv ====
/*
 * Small circular buffer holding returned packets until the core takes
 * them. An entry shows at the output the cycle after its push.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module return_fifo
  import net_pkt_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ret_pkt_s data_i,
  input  logic     v_i,
  output logic     ready_o,
  output ret_pkt_s data_o,
  output logic     v_o,
  input  logic     yumi_i,
  output logic     full_o
);

  localparam int PTR_W = (`RET_DEPTH > 1) ? $clog2(`RET_DEPTH) : 1;
  localparam int CNT_W = $clog2(`RET_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`RET_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`RET_DEPTH);

  ret_pkt_s         mem [`RET_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == LAST_PTR) ? '0 : p + 1'b1;
  endfunction

  assign full_o  = (count == FULL_CNT);
  assign ready_o = ~full_o;
  assign v_o     = (count != '0);
  assign data_o  = mem[rd_ptr];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  a_yumi_when_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o)
    else $error("return entry taken while buffer empty");

endmodule

// ==== src/network_tx.sv ====
/*
 * Builds the outgoing request packet from a core request, gates it on
 * credits and address validity, and steers returned packets to the
 * ifetch, float and int writeback ports.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module network_tx
  import net_pkt_pkg::*;
  import core_req_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // core request side
  input  remote_req_s          remote_req_i,
  input  logic                 remote_req_v_i,
  output logic                 remote_req_yumi_o,

  input  logic                 dram_enable_i,
  input  logic [`X_W-1:0]      tgo_x_i,
  input  logic [`Y_W-1:0]      tgo_y_i,
  input  logic [`X_W-1:0]      my_x_i,
  input  logic [`Y_W-1:0]      my_y_i,
  input  logic [`CREDIT_W-1:0] credits_avail_i,

  // network out
  output req_pkt_s             out_pkt_o,
  output logic                 out_v_o,
  input  logic                 out_ready_i,

  // return buffer head
  input  ret_pkt_s             ret_pkt_i,
  input  logic                 ret_v_i,
  input  logic                 ret_full_i,
  output logic                 ret_yumi_o,

  // core response side
  output logic                 ifetch_v_o,
  output logic [`DATA_W-1:0]   ifetch_instr_o,
  output logic                 float_v_o,
  output wb_resp_s             float_resp_o,
  output logic                 int_v_o,
  output wb_resp_s             int_resp_o,
  output logic                 int_force_o,
  input  logic                 int_yumi_i
);

  logic              invalid_addr;
  logic [`X_W-1:0]   dest_x;
  logic [`Y_W-1:0]   dest_y;
  logic [`ADDR_W-1:0] dest_epa;

  eva_to_npa u_eva_to_npa (
    .eva_i         (remote_req_i.addr),
    .dram_enable_i (dram_enable_i),
    .tgo_x_i       (tgo_x_i),
    .tgo_y_i       (tgo_y_i),
    .x_o           (dest_x),
    .y_o           (dest_y),
    .epa_o         (dest_epa),
    .invalid_o     (invalid_addr)
  );

  always_comb begin
    if (remote_req_i.write_not_read || remote_req_i.is_amo_op) begin
      out_pkt_o.payload.data = remote_req_i.data;
    end else begin
      out_pkt_o.payload.load_info.reserved = '0;
      {out_pkt_o.payload.load_info.float_wb,
       out_pkt_o.payload.load_info.is_unsigned,
       out_pkt_o.payload.load_info.size} = remote_req_i.load_info;
    end

    if (remote_req_i.is_amo_op) begin
      out_pkt_o.op    = e_remote_amo;
      out_pkt_o.op_ex = remote_req_i.amo_type;
    end else begin
      out_pkt_o.op    = remote_req_i.write_not_read ? e_remote_store : e_remote_load;
      out_pkt_o.op_ex = remote_req_i.mask;
    end

    out_pkt_o.addr   = dest_epa;
    out_pkt_o.reg_id = remote_req_i.reg_id;
    out_pkt_o.src_x  = my_x_i;
    out_pkt_o.src_y  = my_y_i;
    out_pkt_o.x      = dest_x;
    out_pkt_o.y      = dest_y;
  end

  // bad addresses are taken and dropped without reaching the network
  assign out_v_o           = remote_req_v_i & (|credits_avail_i) & ~invalid_addr;
  assign remote_req_yumi_o = (out_v_o & out_ready_i) | (remote_req_v_i & invalid_addr);

  assign ifetch_v_o = ret_v_i & (ret_pkt_i.ret_type == e_return_ifetch);
  assign float_v_o  = ret_v_i & (ret_pkt_i.ret_type == e_return_float_wb);
  assign int_v_o    = ret_v_i & ~ifetch_v_o & ~float_v_o;

  assign ifetch_instr_o = ret_pkt_i.data;
  assign float_resp_o   = '{rd: ret_pkt_i.reg_id, data: ret_pkt_i.data};
  assign int_resp_o     = '{rd: ret_pkt_i.reg_id, data: ret_pkt_i.data};

  // full buffer forces the int writeback through
  assign int_force_o = int_v_o & ret_full_i;
  assign ret_yumi_o  = ifetch_v_o | float_v_o | (int_v_o & (int_yumi_i | ret_full_i));

  // credits are counted in the network, never queued for the core
  a_no_credit_ret: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_v_i |-> ret_pkt_i.ret_type != e_return_credit)
    else $error("credit packet reached the return buffer head");

endmodule

// ==== src/tile_net_if.sv ====
/*
 * Network interface of one compute tile. Ties the packet builder and
 * return steering to the credit counter and the return buffer.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module tile_net_if
  import net_pkt_pkg::*;
  import core_req_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  remote_req_s        remote_req_i,
  input  logic               remote_req_v_i,
  output logic               remote_req_yumi_o,

  output req_pkt_s           out_pkt_o,
  output logic               out_v_o,
  input  logic               out_ready_i,
  input  logic               credit_return_i,

  input  ret_pkt_s           ret_pkt_i,
  input  logic               ret_v_i,
  output logic               ret_ready_o,

  output logic               ifetch_v_o,
  output logic [`DATA_W-1:0] ifetch_instr_o,
  output logic               float_v_o,
  output wb_resp_s           float_resp_o,
  output logic               int_v_o,
  output wb_resp_s           int_resp_o,
  output logic               int_force_o,
  input  logic               int_yumi_i,

  input  logic               dram_enable_i,
  input  logic [`X_W-1:0]    tgo_x_i,
  input  logic [`Y_W-1:0]    tgo_y_i,
  input  logic [`X_W-1:0]    my_x_i,
  input  logic [`Y_W-1:0]    my_y_i
);

  logic [`CREDIT_W-1:0] credits;
  logic                 pkt_sent;
  ret_pkt_s             head_pkt;
  logic                 head_v;
  logic                 head_yumi;
  logic                 ret_full;

  // a packet leaves only on the valid/ready handshake
  assign pkt_sent = out_v_o & out_ready_i;

  out_credit_counter u_credits (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .sent_i          (pkt_sent),
    .credit_return_i (credit_return_i),
    .credits_o       (credits)
  );

  return_fifo u_ret_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (ret_pkt_i),
    .v_i     (ret_v_i),
    .ready_o (ret_ready_o),
    .data_o  (head_pkt),
    .v_o     (head_v),
    .yumi_i  (head_yumi),
    .full_o  (ret_full)
  );

  network_tx u_tx (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .remote_req_i      (remote_req_i),
    .remote_req_v_i    (remote_req_v_i),
    .remote_req_yumi_o (remote_req_yumi_o),
    .dram_enable_i     (dram_enable_i),
    .tgo_x_i           (tgo_x_i),
    .tgo_y_i           (tgo_y_i),
    .my_x_i            (my_x_i),
    .my_y_i            (my_y_i),
    .credits_avail_i   (credits),
    .out_pkt_o         (out_pkt_o),
    .out_v_o           (out_v_o),
    .out_ready_i       (out_ready_i),
    .ret_pkt_i         (head_pkt),
    .ret_v_i           (head_v),
    .ret_full_i        (ret_full),
    .ret_yumi_o        (head_yumi),
    .ifetch_v_o        (ifetch_v_o),
    .ifetch_instr_o    (ifetch_instr_o),
    .float_v_o         (float_v_o),
    .float_resp_o      (float_resp_o),
    .int_v_o           (int_v_o),
    .int_resp_o        (int_resp_o),
    .int_force_o       (int_force_o),
    .int_yumi_i        (int_yumi_i)
  );

endmodule

// ==== bench/tile_net_tb.sv ====
/*
 * Testbench for the tile network interface. Reads request, credit and
 * return cases from the case file and checks the DUT against them.
 */
`timescale 1ns/10ps
`include "tile_net_defs.svh"

module tile_net_tb
  import net_pkt_pkg::*, core_req_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam logic [`X_W-1:0] MY_X = 4'd3;
  localparam logic [`Y_W-1:0] MY_Y = 4'd1;

  logic               clk_i;
  logic               rst_n_i;
  remote_req_s        remote_req_i;
  logic               remote_req_v_i;
  logic               remote_req_yumi_o;
  req_pkt_s           out_pkt_o;
  logic               out_v_o;
  logic               out_ready_i;
  logic               credit_return_i;
  ret_pkt_s           ret_pkt_i;
  logic               ret_v_i;
  logic               ret_ready_o;
  logic               ifetch_v_o;
  logic [`DATA_W-1:0] ifetch_instr_o;
  logic               float_v_o;
  wb_resp_s           float_resp_o;
  logic               int_v_o;
  wb_resp_s           int_resp_o;
  logic               int_force_o;
  logic               int_yumi_i;
  logic               dram_enable_i;
  logic [31:0]        lfsr;
  ret_pkt_s           ret_q[$];
  int                 forced_cnt;
  int                 case_no;

  // tile group origin at (1,2), this tile at (3,1)
  tile_net_if u_dut (
    .*,
    .tgo_x_i (4'd1),
    .tgo_y_i (4'd2),
    .my_x_i  (MY_X),
    .my_y_i  (MY_Y)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // taps 32 22 2 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic string case_name(input string field);
    return $sformatf("case %0d %s", case_no, field);
  endfunction

  task automatic drive_ready();
    lfsr = lfsr_step(lfsr);
    out_ready_i <= lfsr[0];
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic wait_taken(output logic saw_v, output req_pkt_s pkt);
    int cycles;
    logic done;
    saw_v = 1'b0;
    pkt = '0;
    done = 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge clk_i);
      if (out_v_o) begin
        saw_v = 1'b1;
        pkt = out_pkt_o;
      end
      done = remote_req_yumi_o;
      cycles++;
      if (cycles > TIMEOUT) abort_run("request was never taken by the DUT");
      @(posedge clk_i);
      // credit strobes last one cycle
      credit_return_i <= 1'b0;
      drive_ready();
    end
    remote_req_v_i <= 1'b0;
  endtask

  task automatic issue_req(input remote_req_s req, input logic dram_en,
                           output logic saw_v, output req_pkt_s pkt);
    @(posedge clk_i);
    remote_req_i <= req;
    remote_req_v_i <= 1'b1;
    dram_enable_i <= dram_en;
    drive_ready();
    wait_taken(saw_v, pkt);
  endtask

  task automatic expect_blocked(input int n);
    repeat (n) begin
      @(negedge clk_i);
      check_val(case_name("blocked"), 0, 32'({out_v_o, remote_req_yumi_o}));
      @(posedge clk_i);
      drive_ready();
    end
  endtask

  task automatic return_credit();
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    @(posedge clk_i);
    credit_return_i <= 1'b0;
  endtask

  task automatic push_ret(input ret_pkt_s pkt);
    int cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    @(posedge clk_i);
    ret_pkt_i <= pkt;
    ret_v_i <= 1'b1;
    while (!done) begin
      @(negedge clk_i);
      done = ret_ready_o;
      cycles++;
      if (cycles > TIMEOUT) abort_run("return buffer never became ready");
      @(posedge clk_i);
    end
    ret_q.push_back(pkt);
    ret_v_i <= 1'b0;
  endtask

  task automatic drain_ret();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    int_yumi_i <= 1'b1;
    while (ret_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) abort_run("returned packets never reached the core ports");
    end
    @(posedge clk_i);
    int_yumi_i <= 1'b0;
  endtask

  // ret_q mirrors the return buffer with the head first
  always @(negedge clk_i) begin : ret_monitor
    ret_pkt_s head;
    wb_resp_s resp;
    logic full;
    if (rst_n_i && (ifetch_v_o || float_v_o || int_v_o)) begin
      if (ret_q.size() == 0) abort_run("core port valid with no packet pending");
      head = ret_q[0];
      full = (head.ret_type == e_return_int_wb) && (ret_q.size() == `RET_DEPTH);
      check_val("ret ifetch_v", 32'(head.ret_type == e_return_ifetch), 32'(ifetch_v_o));
      check_val("ret float_v", 32'(head.ret_type == e_return_float_wb), 32'(float_v_o));
      check_val("ret int_v", 32'(head.ret_type == e_return_int_wb), 32'(int_v_o));
      check_val("ret int_force", 32'(full), 32'(int_force_o));
      if (ifetch_v_o) begin
        check_val("ret ifetch data", head.data, ifetch_instr_o);
      end else begin
        resp = float_v_o ? float_resp_o : int_resp_o;
        check_val("ret data", head.data, resp.data);
        check_val("ret reg id", 32'(head.reg_id), 32'(resp.rd));
      end
      if (full) forced_cnt++;
      if (head.ret_type != e_return_int_wb || int_yumi_i || full) void'(ret_q.pop_front());
    end
  end

  initial begin
    int fd;
    int n;
    string line;
    logic [63:0] kind;
    logic [31:0] f [16];
    remote_req_s req;
    req_pkt_s pkt;
    ret_pkt_s rp;
    logic saw_v;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    remote_req_i = '0;
    remote_req_v_i = 1'b0;
    out_ready_i = 1'b0;
    credit_return_i = 1'b0;
    ret_pkt_i = '0;
    ret_v_i = 1'b0;
    int_yumi_i = 1'b0;
    dram_enable_i = 1'b1;
    lfsr = 32'h6adc2a39;
    forced_cnt = 0;
    case_no = 0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("reset valids", 0, 32'({out_v_o, ifetch_v_o, float_v_o, int_v_o, int_force_o}));
    fd = $fopen("bench/tile_net_cases.txt", "r");
    if (fd == 0) abort_run("cannot open bench/tile_net_cases.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        void'($fgets(line, fd));
        continue;
      end
      case_no++;
      if (kind == "req") begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
        if (n != 16) abort_run("malformed req line in case file");
        req.addr = f[0];
        req.data = f[1];
        req.mask = f[2][3:0];
        req.write_not_read = f[3][0];
        req.is_amo_op = f[4][0];
        req.amo_type = f[5][3:0];
        req.reg_id = f[6][4:0];
        req.load_info = f[7][3:0];
        issue_req(req, f[8][0], saw_v, pkt);
        check_val(case_name("valid"), f[9], 32'(saw_v));
        if (saw_v) begin
          check_val(case_name("x"), f[10], 32'(pkt.x));
          check_val(case_name("y"), f[11], 32'(pkt.y));
          check_val(case_name("epa"), f[12], 32'(pkt.addr));
          check_val(case_name("op"), f[13], 32'(pkt.op));
          check_val(case_name("op_ex"), f[14], 32'(pkt.op_ex));
          check_val(case_name("payload"), f[15], pkt.payload.data);
          check_val(case_name("reg id"), f[6], 32'(pkt.reg_id));
          check_val(case_name("src x"), 32'(MY_X), 32'(pkt.src_x));
          check_val(case_name("src y"), 32'(MY_Y), 32'(pkt.src_y));
          return_credit();
        end
      end else if (kind == "credit") begin
        n = $fscanf(fd, "%h %h", f[0], f[1]);
        if (n != 2) abort_run("malformed credit line in case file");
        req = '0;
        req.addr = f[0];
        req.data = f[0];
        req.mask = 4'hf;
        req.write_not_read = 1'b1;
        repeat (`MAX_CREDITS) issue_req(req, 1'b1, saw_v, pkt);
        @(posedge clk_i);
        remote_req_v_i <= 1'b1;
        expect_blocked(int'(f[1]));
        credit_return_i <= 1'b1;
        wait_taken(saw_v, pkt);
        check_val(case_name("after credit"), 1, 32'(saw_v));
        @(posedge clk_i);
        remote_req_v_i <= 1'b1;
        expect_blocked(int'(f[1]));
        remote_req_v_i <= 1'b0;
        repeat (`MAX_CREDITS) return_credit();
      end else if (kind == "ret") begin
        n = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
        if (n != 3) abort_run("malformed ret line in case file");
        rp.ret_type = ret_type_e'(f[0][1:0]);
        rp.data = f[1];
        rp.reg_id = f[2][4:0];
        push_ret(rp);
      end else if (kind == "drain") begin
        n = $fscanf(fd, "%h", f[0]);
        if (n != 1) abort_run("malformed drain line in case file");
        drain_ret();
        check_val(case_name("forced"), f[0], 32'(forced_cnt));
        forced_cnt = 0;
      end else begin
        abort_run("unknown case kind in case file");
      end
    end
    $fclose(fd);
    if (case_no == 0) begin
      abort_run("no cases found in case file");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+src
src/net_pkt_pkg.sv
src/core_req_pkg.sv
src/eva_to_npa.sv
src/out_credit_counter.sv
src/return_fifo.sv
src/network_tx.sv
src/tile_net_if.sv
bench/tile_net_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tile network interface testbench from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tile_net_tb -o tile_net_sim &&
./obj_dir/tile_net_sim || { echo "simulation did not pass"; exit 1; }

// ==== bench/tile_net_cases.txt ====
# req: eva data mask wnr amo amo_type reg load_info dram_en, then valid x y epa op op_ex payload
# ret: type(0 int 1 float 2 ifetch) data reg; drain: forced count; credit: eva blocked_cycles
req 80000124 deadbeef f 1 0 0 3 0 1 1 1 8 0011 1 f deadbeef
req 80003f5c 12345678 0 0 0 0 7 b 1 1 2 8 03f7 0 0 0000000b
req 48400100 cafef00d 3 0 1 5 1f 0 1 1 3 3 0040 2 5 cafef00d
req 7f83fffc 0000a5a5 1 1 0 0 2 0 1 1 0 0 ffff 1 1 0000a5a5
req 2ac048d0 ffffffff 2 0 0 0 4 6 1 1 5 6 1234 0 2 00000006
req 10000000 00000001 f 1 0 0 1 0 1 0 0 0 0 0 0 0
req 00000040 00000002 f 1 0 0 1 0 1 0 0 0 0 0 0 0
req 80000124 00000003 f 1 0 0 1 0 0 0 0 0 0 0 0 0
credit 48400100 3
ret 2 00000013 0
ret 1 3f800000 5
ret 0 11111111 9
drain 0
ret 0 22222222 a
ret 0 33333333 b
drain 1
ret 0 44444444 c
ret 2 00100073 0
drain 1
ret 1 40490fdb 1f
ret 0 55555555 1
ret 0 66666666 2
drain 1
